// ==== rtl/phy_mgmt_pkg.sv ====
// PHY management definitions
package phy_mgmt_pkg;

    // MDIO start code, only clause 22 is issued
    typedef enum logic [1:0] {
        ST_CLAUSE22 = 2'b01
    } mdio_st_e;

    // MDIO opcodes
    typedef enum logic [1:0] {
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10
    } mdio_op_e;

    // PHY strapped to MDIO address 3
    localparam logic [4:0] PHY_ADDR = 5'h03;

    // clause-22 indirect access registers
    localparam logic [4:0] REG_REGCR = 5'h0D;
    localparam logic [4:0] REG_ADDAR = 5'h0E;

    // vendor specific MMD device
    localparam logic [4:0] MMD_DEV_VENDOR = 5'h1F;

    // REGCR function field, data with no post increment
    localparam logic [15:0] REGCR_DATA_FLAG = 16'h4000;

    localparam logic [1:0] MDIO_TA_WRITE = 2'b10;

    // frame geometry
    localparam int MDIO_PREAMBLE_BITS = 32;
    localparam int MDIO_FRAME_BITS = 32;
    localparam int MDIO_SHIFT_BITS = MDIO_PREAMBLE_BITS + MDIO_FRAME_BITS;

    // 125 MHz / 8 gives MDC at 15.625 MHz
    localparam int MDC_HALF_CYCLES = 4;
    localparam int MDC_BIT_CYCLES = 2 * MDC_HALF_CYCLES;

    localparam int INIT_WRITE_COUNT = 3;
    localparam int INIT_IDX_W = $clog2(INIT_WRITE_COUNT);

    // extended register write
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
    } ext_write_t;

    // clause-22 write, fixed fields are added by the master
    typedef struct packed {
        logic [4:0]  reg_addr;
        logic [15:0] data;
    } mdio_write_t;

    // CFG4 autoneg timer, SGMIICTL1 clock out, 10M_SGMII_CFG
    localparam ext_write_t INIT_WRITES [INIT_WRITE_COUNT] = '{
        '{addr: 16'h0031, data: 16'h0070},
        '{addr: 16'h00D3, data: 16'h4000},
        '{addr: 16'h016F, data: 16'h0015}
    };

endpackage

// ==== rtl/phy_init_seq.sv ====
// PHY init write sequencer
module phy_init_seq #(
    parameter int INIT_DELAY_CYCLES = 2**20 - 1
) (
    input  logic                    clk_125mhz,
    input  logic                    rst_125mhz,
    output phy_mgmt_pkg::ext_write_t ext_write,
    output logic                    ext_valid,
    input  logic                    ext_ready,
    output logic                    init_done
);

    import phy_mgmt_pkg::*;

    localparam int DELAY_W = $clog2(INIT_DELAY_CYCLES + 2);

    typedef enum logic [1:0] {
        SEQ_DELAY,
        SEQ_ISSUE,
        SEQ_WAIT,
        SEQ_DONE
    } seq_state_e;

    seq_state_e              state;
    logic [DELAY_W-1:0]      delay_cnt;
    logic [INIT_IDX_W-1:0]   table_idx;
    ext_write_t              ext_write_reg;
    logic                    ext_valid_reg;
    logic                    init_done_reg;

    assign ext_write = ext_write_reg;
    assign ext_valid = ext_valid_reg;
    assign init_done = init_done_reg;

    // control state
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= SEQ_DELAY;
            delay_cnt <= DELAY_W'(INIT_DELAY_CYCLES);
            table_idx <= '0;
            ext_valid_reg <= 1'b0;
            init_done_reg <= 1'b0;
        end else begin
            case (state)
                SEQ_DELAY: begin
                    // hold off while the PHY comes out of reset
                    if (delay_cnt == '0) begin
                        state <= SEQ_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                SEQ_ISSUE: begin
                    ext_valid_reg <= 1'b1;
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (ext_ready) begin
                        ext_valid_reg <= 1'b0;
                        if (table_idx == INIT_IDX_W'(INIT_WRITE_COUNT - 1)) begin
                            init_done_reg <= 1'b1;
                            state <= SEQ_DONE;
                        end else begin
                            table_idx <= table_idx + 1'b1;
                            state <= SEQ_ISSUE;
                        end
                    end
                end
                SEQ_DONE: begin
                    // stay here until the next reset
                    state <= SEQ_DONE;
                end
                default: begin
                    state <= SEQ_DELAY;
                end
            endcase
        end
    end

    // table entry held for the expander
    always_ff @(posedge clk_125mhz) begin
        if (state == SEQ_ISSUE) begin
            ext_write_reg <= INIT_WRITES[table_idx];
        end
    end

    // payload must not move while the expander is busy
    a_ext_write_stable: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        ext_valid && !ext_ready |=> $stable(ext_write)
    );

endmodule

// ==== rtl/mmd_write_expander.sv ====
// MMD indirect write expander
module mmd_write_expander (
    input  logic                     clk_125mhz,
    input  logic                     rst_125mhz,
    input  phy_mgmt_pkg::ext_write_t  ext_write,
    input  logic                     ext_valid,
    output logic                     ext_ready,
    output phy_mgmt_pkg::mdio_write_t cmd,
    output logic                     cmd_valid,
    input  logic                     cmd_ready
);

    import phy_mgmt_pkg::*;

    // indirect access steps through REGCR and ADDAR
    typedef enum logic [2:0] {
        X_IDLE,
        X_REGCR_DEV,
        X_ADDAR_ADDR,
        X_REGCR_DATA,
        X_ADDAR_DATA
    } exp_state_e;

    exp_state_e  state;
    ext_write_t  ext_write_reg;
    logic        cmd_valid_reg;

    assign ext_ready = (state == X_IDLE);
    assign cmd_valid = cmd_valid_reg;

    // build the clause-22 word for the current step
    always_comb begin
        case (state)
            X_REGCR_DEV: begin
                cmd.reg_addr = REG_REGCR;
                cmd.data = 16'(MMD_DEV_VENDOR);
            end
            X_ADDAR_ADDR: begin
                cmd.reg_addr = REG_ADDAR;
                cmd.data = ext_write_reg.addr;
            end
            X_REGCR_DATA: begin
                cmd.reg_addr = REG_REGCR;
                cmd.data = REGCR_DATA_FLAG | 16'(MMD_DEV_VENDOR);
            end
            default: begin
                cmd.reg_addr = REG_ADDAR;
                cmd.data = ext_write_reg.data;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= X_IDLE;
            cmd_valid_reg <= 1'b0;
        end else if (state == X_IDLE) begin
            if (ext_valid) begin
                cmd_valid_reg <= 1'b1;
                state <= X_REGCR_DEV;
            end
        end else if (cmd_valid_reg && cmd_ready) begin
            case (state)
                X_REGCR_DEV: state <= X_ADDAR_ADDR;
                X_ADDAR_ADDR: state <= X_REGCR_DATA;
                X_REGCR_DATA: state <= X_ADDAR_DATA;
                default: begin
                    // fourth write taken, ready for the next entry
                    cmd_valid_reg <= 1'b0;
                    state <= X_IDLE;
                end
            endcase
        end
    end

    // latched on accept, held for all four steps
    always_ff @(posedge clk_125mhz) begin
        if (ext_valid && ext_ready) begin
            ext_write_reg <= ext_write;
        end
    end

    a_no_cmd_when_idle: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        (state == X_IDLE) |-> !cmd_valid
    );

endmodule

// ==== rtl/mdio_master.sv ====
// MDIO write master
module mdio_master (
    input  logic                     clk_125mhz,
    input  logic                     rst_125mhz,
    input  phy_mgmt_pkg::mdio_write_t cmd,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    output logic                     mdc,
    output logic                     mdio_o,
    output logic                     mdio_t
);

    import phy_mgmt_pkg::*;

    localparam int PRESCALE_W = $clog2(MDC_BIT_CYCLES);
    localparam int BIT_CNT_W = $clog2(MDIO_FRAME_BITS);

    typedef enum logic [1:0] {
        M_IDLE,
        M_PREAMBLE,
        M_FRAME
    } mdio_state_e;

    mdio_state_e                 state;
    logic [PRESCALE_W-1:0]       prescale_cnt;
    logic [BIT_CNT_W-1:0]        bit_cnt;
    logic [MDIO_SHIFT_BITS-1:0]  shift_reg;
    logic [MDIO_SHIFT_BITS-1:0]  frame_word;
    logic                        mdc_reg;
    logic                        mdio_o_reg;
    logic                        mdio_t_reg;
    logic                        bit_end;
    logic                        half_end;

    assign cmd_ready = (state == M_IDLE);
    assign mdc = mdc_reg;
    assign mdio_o = mdio_o_reg;
    assign mdio_t = mdio_t_reg;

    // preamble then st, op, phy, reg, ta, data, msb first
    assign frame_word = {
        {MDIO_PREAMBLE_BITS{1'b1}},
        ST_CLAUSE22,
        OP_WRITE,
        PHY_ADDR,
        cmd.reg_addr,
        MDIO_TA_WRITE,
        cmd.data
    };

    assign half_end = (prescale_cnt == PRESCALE_W'(MDC_HALF_CYCLES - 1));
    assign bit_end = (prescale_cnt == PRESCALE_W'(MDC_BIT_CYCLES - 1));

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= M_IDLE;
            prescale_cnt <= '0;
            bit_cnt <= '0;
            mdc_reg <= 1'b0;
            mdio_o_reg <= 1'b1;
            mdio_t_reg <= 1'b1;
        end else begin
            case (state)
                M_IDLE: begin
                    if (cmd_valid) begin
                        // first preamble bit goes out next cycle
                        prescale_cnt <= '0;
                        bit_cnt <= '0;
                        mdc_reg <= 1'b0;
                        mdio_o_reg <= frame_word[MDIO_SHIFT_BITS-1];
                        mdio_t_reg <= 1'b0;
                        state <= M_PREAMBLE;
                    end
                end
                M_PREAMBLE, M_FRAME: begin
                    prescale_cnt <= prescale_cnt + 1'b1;
                    if (half_end) begin
                        // rising MDC, PHY samples here
                        mdc_reg <= 1'b1;
                    end
                    if (bit_end) begin
                        prescale_cnt <= '0;
                        mdc_reg <= 1'b0;
                        mdio_o_reg <= shift_reg[MDIO_SHIFT_BITS-2];
                        bit_cnt <= bit_cnt + 1'b1;
                        if (state == M_PREAMBLE &&
                            bit_cnt == BIT_CNT_W'(MDIO_PREAMBLE_BITS - 1)) begin
                            bit_cnt <= '0;
                            state <= M_FRAME;
                        end else if (state == M_FRAME &&
                                     bit_cnt == BIT_CNT_W'(MDIO_FRAME_BITS - 1)) begin
                            // frame finished, release the line
                            bit_cnt <= '0;
                            mdio_o_reg <= 1'b1;
                            mdio_t_reg <= 1'b1;
                            state <= M_IDLE;
                        end
                    end
                end
                default: begin
                    mdio_t_reg <= 1'b1;
                    state <= M_IDLE;
                end
            endcase
        end
    end

    // bit in flight sits at the top
    always_ff @(posedge clk_125mhz) begin
        if (state == M_IDLE && cmd_valid) begin
            shift_reg <= frame_word;
        end else if (state != M_IDLE && bit_end) begin
            shift_reg <= {shift_reg[MDIO_SHIFT_BITS-2:0], 1'b0};
        end
    end

    a_mdio_t_busy: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        !mdio_t == (state != M_IDLE)
    );

endmodule

// ==== rtl/phy_mgmt_core.sv ====
// PHY management core
module phy_mgmt_core #(
    parameter int INIT_DELAY_CYCLES = 2**20 - 1
) (
    input  logic clk_125mhz,
    input  logic rst_125mhz,
    output logic phy_reset_n,
    output logic phy_mdc,
    output logic phy_mdio_o,
    output logic phy_mdio_t,
    output logic init_done
);

    import phy_mgmt_pkg::*;

    ext_write_t  ext_write;
    logic        ext_valid;
    logic        ext_ready;
    mdio_write_t cmd;
    logic        cmd_valid;
    logic        cmd_ready;

    // PHY held in reset with the core
    assign phy_reset_n = !rst_125mhz;

    phy_init_seq #(
        .INIT_DELAY_CYCLES(INIT_DELAY_CYCLES)
    ) u_init_seq (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .ext_write(ext_write),
        .ext_valid(ext_valid),
        .ext_ready(ext_ready),
        .init_done(init_done)
    );

    mmd_write_expander u_expander (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .ext_write(ext_write),
        .ext_valid(ext_valid),
        .ext_ready(ext_ready),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready)
    );

    mdio_master u_mdio_master (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .mdc(phy_mdc),
        .mdio_o(phy_mdio_o),
        .mdio_t(phy_mdio_t)
    );

endmodule

// ==== test/mdio_phy_model.sv ====
// MDIO PHY model
module mdio_phy_model (
    input logic mdc,
    input logic mdio_o,
    input logic mdio_t
);
    timeunit 1ns;
    timeprecision 1ps;

    import phy_mgmt_pkg::*;

    // preamble plus one clause-22 frame
    localparam int CAPTURE_BITS = 64;

    logic [CAPTURE_BITS-1:0] shift_bits = '0;
    int                      bit_count = 0;
    int                      format_errors = 0;
    int                      activity_events = 0;
    mdio_write_t             frames[$];

    // check the fixed fields of a full capture and queue the write
    task automatic decode_frame(input logic [CAPTURE_BITS-1:0] bits);
        mdio_write_t frame;
        logic        ok;
        ok = 1'b1;
        if (bits[63:32] !== 32'hFFFF_FFFF) begin
            $display("model: preamble is not 32 ones (%h)", bits[63:32]);
            ok = 1'b0;
        end
        if (bits[31:30] !== 2'b01) begin
            $display("model: start code is not clause 22 (%b)", bits[31:30]);
            ok = 1'b0;
        end
        if (bits[29:28] !== 2'b01) begin
            $display("model: opcode is not a write (%b)", bits[29:28]);
            ok = 1'b0;
        end
        if (bits[27:23] !== 5'd3) begin
            $display("model: frame addressed to PHY %0d instead of 3", bits[27:23]);
            ok = 1'b0;
        end
        if (bits[17:16] !== 2'b10) begin
            $display("model: write turnaround is %b instead of 10", bits[17:16]);
            ok = 1'b0;
        end
        if (!ok) begin
            format_errors++;
        end
        frame.reg_addr = bits[22:18];
        frame.data = bits[15:0];
        frames.push_back(frame);
    endtask

    // PHY samples on rising MDC while the master drives the line
    always @(posedge mdc or posedge mdio_t) begin
        if (mdio_t) begin
            // line released, a partial frame is dropped
            bit_count = 0;
        end else begin
            shift_bits = {shift_bits[CAPTURE_BITS-2:0], mdio_o};
            bit_count++;
            if (bit_count == CAPTURE_BITS) begin
                decode_frame(shift_bits);
                bit_count = 0;
            end
        end
    end

    // any MDC edge or the line being taken counts as activity
    always @(mdc or negedge mdio_t) begin
        activity_events++;
    end

endmodule

// ==== test/tb_phy_mgmt_core.sv ====
// PHY management core testbench
module tb_phy_mgmt_core;
    timeunit 1ns;
    timeprecision 1ps;

    import phy_mgmt_pkg::*;

    localparam int DELAY_CYCLES = 100;
    // 512 cycles per frame plus handshake slack
    localparam int FRAME_TIMEOUT = 600;
    localparam int QUIET_CYCLES = 2000;

    logic clk_125mhz;
    logic rst_125mhz;
    logic phy_reset_n;
    logic phy_mdc;
    logic phy_mdio_o;
    logic phy_mdio_t;
    logic init_done;

    int value_errors = 0;
    int timeouts = 0;

    phy_mgmt_core #(
        .INIT_DELAY_CYCLES(DELAY_CYCLES)
    ) dut (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .phy_reset_n(phy_reset_n),
        .phy_mdc(phy_mdc),
        .phy_mdio_o(phy_mdio_o),
        .phy_mdio_t(phy_mdio_t),
        .init_done(init_done)
    );

    mdio_phy_model phy_model (
        .mdc(phy_mdc),
        .mdio_o(phy_mdio_o),
        .mdio_t(phy_mdio_t)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    // drive and sample point 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_125mhz);
        #1;
    endtask

    task automatic check_frame(input string name, input mdio_write_t exp, input mdio_write_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected reg %h data %h, actual reg %h data %h",
                     name, exp.reg_addr, exp.data, act.reg_addr, act.data);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // write n of the sequence as REGCR dev, ADDAR addr, REGCR data flag, ADDAR data
    function automatic mdio_write_t expected_frame(input int n);
        ext_write_t  entry;
        mdio_write_t frame;
        entry = INIT_WRITES[n / 4];
        case (n % 4)
            0: frame = {5'h0D, 16'h001F};
            1: frame = {5'h0E, entry.addr};
            2: frame = {5'h0D, 16'h401F};
            default: frame = {5'h0E, entry.data};
        endcase
        return frame;
    endfunction

    task automatic reset_dut(input string name);
        rst_125mhz = 1'b1;
        repeat (5) begin
            next_cycle();
            check_level(name, 1'b0, phy_reset_n);
        end
        rst_125mhz = 1'b0;
    endtask

    task automatic wait_frames(input string name, input int count);
        int cycles;
        cycles = 0;
        while (phy_model.frames.size() < count &&
               cycles < count * FRAME_TIMEOUT + DELAY_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (phy_model.frames.size() < count) begin
            timeouts++;
            $display("%s: timed out waiting for %0d MDIO frames, only %0d arrived",
                     name, count, phy_model.frames.size());
        end
    endtask

    task automatic check_frames(input string name, input int count);
        for (int i = 0; i < count; i++) begin
            if (phy_model.frames.size() == 0) begin
                $display("%s: frame %0d never arrived", name, i);
                return;
            end
            check_frame(name, expected_frame(i), phy_model.frames.pop_front());
        end
    endtask

    // no MDIO activity and no done flag during the start-up delay
    task automatic test_startup_quiet(input string name);
        int activity;
        activity = phy_model.activity_events;
        repeat (DELAY_CYCLES) begin
            next_cycle();
            check_level(name, 1'b1, phy_reset_n);
            check_level(name, 1'b1, phy_mdio_t);
            check_level(name, 1'b0, phy_mdc);
            check_level(name, 1'b0, init_done);
        end
        check_level(name, 1'b0, phy_model.activity_events != activity);
    endtask

    task automatic test_frame_sequence(input string name);
        wait_frames(name, 4 * INIT_WRITE_COUNT);
        check_frames(name, 4 * INIT_WRITE_COUNT);
    endtask

    task automatic test_frame_format(input string name);
        check_level(name, 1'b0, phy_model.format_errors != 0);
    endtask

    task automatic test_done_idle(input string name);
        int cycles;
        cycles = 0;
        while (init_done !== 1'b1 && cycles < FRAME_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (init_done !== 1'b1) begin
            timeouts++;
            $display("%s: init_done did not rise after the last frame", name);
        end
        repeat (QUIET_CYCLES) begin
            next_cycle();
            check_level(name, 1'b1, init_done);
        end
        check_level(name, 1'b0, phy_model.frames.size() != 0);
    endtask

    // reset during the fifth frame restarts from the first write
    task automatic test_mid_reset(input string name);
        int cycles;
        reset_dut(name);
        wait_frames(name, 4);
        check_frames(name, 4);
        cycles = 0;
        while (phy_model.bit_count < 16 && cycles < FRAME_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (phy_model.bit_count < 16) begin
            timeouts++;
            $display("%s: fifth frame did not start", name);
        end
        reset_dut(name);
        // partial capture dropped once the line is released
        check_level(name, 1'b0, phy_model.bit_count != 0);
        test_startup_quiet(name);
        test_frame_sequence(name);
        test_frame_format(name);
    endtask

    initial begin
        rst_125mhz = 1'b1;
        reset_dut("reset");
        test_startup_quiet("startup_quiet");
        test_frame_sequence("frame_sequence");
        test_frame_format("frame_format");
        test_done_idle("done_idle");
        test_mid_reset("mid_reset");
        $display("errors: value %0d, timeout %0d, format %0d",
                 value_errors, timeouts, phy_model.format_errors);
        if (value_errors == 0 && timeouts == 0 && phy_model.format_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== phy_mgmt_core.f ====
rtl/phy_mgmt_pkg.sv
rtl/phy_init_seq.sv
rtl/mmd_write_expander.sv
rtl/mdio_master.sv
rtl/phy_mgmt_core.sv
test/mdio_phy_model.sv
test/tb_phy_mgmt_core.sv

// ==== Makefile ====
# Verilator build for the PHY management core testbench

VERILATOR ?= verilator
TOP       ?= tb_phy_mgmt_core
FILELIST  ?= phy_mgmt_core.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= === PASS ===

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
